// ==== rename_retire.f ====
+incdir+verilog
verilog/rename_pkg.sv
verilog/rob_pkg.sv
verilog/free_list.sv
verilog/map_table.sv
verilog/arch_map.sv
verilog/rob.sv
verilog/rename_retire.sv
verification/rename_retire_checker.sv
verification/rename_retire_tb.sv

// ==== verification/rename_retire_checker.sv ====
`timescale 1ns/100ps
`include "core_config.svh"

module rename_retire_checker (
  input logic                                   clock,
  input logic                                   reset,
  input logic                                   dispatch_en,
  input logic                                   rollback_en,
  input logic                                   dispatch_ready,
  input logic                                   recover,
  input rename_pkg::phys_reg_t [`NUM_SUPER-1:0] t_idx,
  input logic                  [`NUM_SUPER-1:0] retire_en,
  input rob_pkg::rob_state_t                    rob_state
);

  import rob_pkg::*;

  // failed properties so far
  int violations = 0;

  retire_in_order: assert property (@(posedge clock) disable iff (reset)
    retire_en[1] |-> retire_en[0])
    else begin
      $error("retire_en[1] high without retire_en[0]");
      violations++;
    end

  stall_after_rollback: assert property (@(posedge clock) disable iff (reset)
    rollback_en |=> !dispatch_ready)
    else begin
      $error("dispatch_ready high in the cycle after a rollback");
      violations++;
    end

  distinct_alloc: assert property (@(posedge clock) disable iff (reset)
    dispatch_en |-> t_idx[0] != t_idx[1])
    else begin
      $error("both dispatch slots got the same physical register");
      violations++;
    end

  recover_pulse: assert property (@(posedge clock) disable iff (reset)
    recover |=> !recover)
    else begin
      $error("recover held for more than one cycle");
      violations++;
    end

  // a rollback starts the drain
  drain_after_rollback: assert property (@(posedge clock) disable iff (reset)
    rollback_en |=> rob_state == rob_draining)
    else begin
      $error("ROB not draining in the cycle after a rollback");
      violations++;
    end

endmodule

// ==== verification/rename_retire_tb.sv ====
`timescale 1ns/100ps
`include "core_config.svh"

module rename_retire_tb;

  import rename_pkg::*;
  import rob_pkg::*;

  localparam int timeout_cycles = 2000;

  logic clock;
  logic reset;
  logic dispatch_en;
  arch_reg_t [`NUM_SUPER-1:0] dest_idx;
  logic [`NUM_SUPER-1:0] halt;
  logic [`NUM_SUPER-1:0] complete_en;
  rob_idx_t [`NUM_SUPER-1:0] complete_idx;
  logic rollback_en;
  rob_idx_t rollback_idx;
  logic dispatch_ready;
  rob_idx_t [`NUM_SUPER-1:0] rob_idx;
  phys_reg_t [`NUM_SUPER-1:0] t_idx;
  logic [`NUM_SUPER-1:0] retire_en;
  arch_reg_t [`NUM_SUPER-1:0] retire_dest;
  phys_reg_t [`NUM_SUPER-1:0] retire_t_idx;
  phys_reg_t [`NUM_SUPER-1:0] retire_told_idx;
  logic [`NUM_SUPER-1:0] halt_out;

  // reference model
  logic [`NUM_PR-1:0] m_free;
  phys_reg_t m_spec [`NUM_ARCH];
  phys_reg_t m_arch [`NUM_ARCH];
  arch_reg_t m_dest [`NUM_ROB];
  phys_reg_t m_t [`NUM_ROB];
  phys_reg_t m_told [`NUM_ROB];
  logic [`NUM_ROB-1:0] m_complete;
  logic [`NUM_ROB-1:0] m_halt;
  rob_idx_t inflight [$];
  rob_idx_t m_tail;
  logic m_draining;

  logic [31:0] lfsr_state = 32'h65cb_b9ba;
  int cycle_count = 0;
  int rollbacks = 0;
  int halts_retired = 0;
  int full_seen = 0;

  rename_retire UUT (.*);

  bind rename_retire rename_retire_checker u_checker (
    .clock          (clock),
    .reset          (reset),
    .dispatch_en    (dispatch_en),
    .rollback_en    (rollback_en),
    .dispatch_ready (dispatch_ready),
    .recover        (recover),
    .t_idx          (t_idx),
    .retire_en      (retire_en),
    .rob_state      (u_rob.state)
  );

  initial begin
    clock = 1'b0;
    forever #2 clock = ~clock;
  end

  // taps 32 22 2 1
  function automatic logic [31:0] rand_bits(input int count);
    logic [31:0] value;
    logic fb;
    value = '0;
    for (int i = 0; i < count; i++) begin
      fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
      lfsr_state = {lfsr_state[30:0], fb};
      value = {value[30:0], fb};
    end
    return value;
  endfunction

  task automatic reset_model();
    for (int r = 0; r < `NUM_ARCH; r++) begin
      m_spec[r] = phys_reg_t'(r);
      m_arch[r] = phys_reg_t'(r);
    end
    for (int p = 0; p < `NUM_PR; p++) begin
      m_free[p] = (p >= `NUM_ARCH);
    end
    inflight.delete();
    m_tail = '0;
    m_draining = 1'b0;
    m_complete = '0;
    m_halt = '0;
  endtask

  // n-th lowest free register
  function automatic phys_reg_t lowest_free(input int which);
    int seen;
    seen = 0;
    for (int p = 0; p < `NUM_PR; p++) begin
      if (m_free[p]) begin
        if (seen == which) begin
          return phys_reg_t'(p);
        end
        seen++;
      end
    end
    return '0;
  endfunction

  function automatic logic model_ready();
    logic halt_held;
    halt_held = 1'b0;
    foreach (inflight[i]) begin
      halt_held = halt_held | m_halt[inflight[i]];
    end
    return !m_draining && !halt_held && (`NUM_ROB - inflight.size() >= 2) &&
           ($countones(m_free) >= 2);
  endfunction

  // oldest entries retire once complete but not during a rollback
  function automatic logic [`NUM_SUPER-1:0] expected_retire();
    logic [`NUM_SUPER-1:0] result;
    result = '0;
    for (int s = 0; s < `NUM_SUPER; s++) begin
      if (inflight.size() > s && m_complete[inflight[s]] && !rollback_en &&
          (s == 0 || result[s-1])) begin
        result[s] = 1'b1;
      end
    end
    return result;
  endfunction

  task automatic update_model(input logic [`NUM_SUPER-1:0] retiring);
    phys_reg_t alloc [`NUM_SUPER];
    phys_reg_t told [`NUM_SUPER];
    rob_idx_t slot;
    int pos;
    logic recovering;
    recovering = m_draining && inflight.size() == 0;
    // names come from the state before this edge
    for (int s = 0; s < `NUM_SUPER; s++) begin
      alloc[s] = lowest_free(s);
      told[s] = m_spec[dest_idx[s]];
      if (complete_en[s]) begin
        m_complete[complete_idx[s]] = 1'b1;
      end
    end
    if (dest_idx[1] == dest_idx[0]) begin
      told[1] = alloc[0];
    end
    for (int s = 0; s < `NUM_SUPER; s++) begin
      if (retiring[s]) begin
        slot = inflight.pop_front();
        m_arch[m_dest[slot]] = m_t[slot];
        m_free[m_told[slot]] = 1'b1;
        halts_retired += m_halt[slot];
      end
    end
    if (dispatch_en) begin
      for (int s = 0; s < `NUM_SUPER; s++) begin
        slot = m_tail + rob_idx_t'(s);
        m_dest[slot] = dest_idx[s];
        m_t[slot] = alloc[s];
        m_told[slot] = told[s];
        m_halt[slot] = halt[s];
        m_complete[slot] = 1'b0;
        m_free[alloc[s]] = 1'b0;
        m_spec[dest_idx[s]] = alloc[s];
        inflight.push_back(slot);
      end
      m_tail = m_tail + rob_idx_t'(`NUM_SUPER);
    end
    if (rollback_en) begin
      pos = -1;
      foreach (inflight[i]) begin
        if (inflight[i] == rollback_idx) begin
          pos = i;
        end
      end
      if (pos >= 0) begin
        // drop everything younger than the branch
        while (inflight.size() > pos + 1) begin
          void'(inflight.pop_back());
        end
        m_tail = rollback_idx + rob_idx_t'(1);
        m_draining = 1'b1;
        rollbacks++;
      end
    end
    if (recovering) begin
      m_free = '1;
      for (int r = 0; r < `NUM_ARCH; r++) begin
        m_spec[r] = m_arch[r];
        m_free[m_arch[r]] = 1'b0;
      end
      m_draining = 1'b0;
    end
  endtask

  task automatic report_failure();
    $display("Something failed");
    $fatal(1);
  endtask

  task automatic compare_phys(input string name, input phys_reg_t actual,
                              input phys_reg_t expected);
    if (actual !== expected) begin
      $display("Error at %0t ns: %s is %0d, expected %0d", $time, name, actual, expected);
      report_failure();
    end
  endtask

  task automatic compare_arch(input string name, input arch_reg_t actual,
                              input arch_reg_t expected);
    if (actual !== expected) begin
      $display("Error at %0t ns: %s is %0d, expected %0d", $time, name, actual, expected);
      report_failure();
    end
  endtask

  task automatic compare_rob_idx(input string name, input rob_idx_t actual,
                                 input rob_idx_t expected);
    if (actual !== expected) begin
      $display("Error at %0t ns: %s is %0d, expected %0d", $time, name, actual, expected);
      report_failure();
    end
  endtask

  task automatic compare_bit(input string name, input logic actual, input logic expected);
    if (actual !== expected) begin
      $display("Error at %0t ns: %s is %b, expected %b", $time, name, actual, expected);
      report_failure();
    end
  endtask

  always @(posedge clock) begin
    logic [`NUM_SUPER-1:0] exp_retire;
    rob_idx_t slot;
    if (reset) begin
      reset_model();
    end else begin
      if (UUT.u_checker.violations != 0) begin
        $display("A checker property failed before %0t ns", $time);
        report_failure();
      end
      exp_retire = expected_retire();
      compare_bit("dispatch_ready", dispatch_ready, model_ready() && !rollback_en);
      for (int s = 0; s < `NUM_SUPER; s++) begin
        compare_bit($sformatf("retire_en[%0d]", s), retire_en[s], exp_retire[s]);
        if (exp_retire[s]) begin
          slot = inflight[s];
          compare_arch($sformatf("retire_dest[%0d]", s), retire_dest[s], m_dest[slot]);
          compare_phys($sformatf("retire_t_idx[%0d]", s), retire_t_idx[s], m_t[slot]);
          compare_phys($sformatf("retire_told_idx[%0d]", s), retire_told_idx[s], m_told[slot]);
          compare_bit($sformatf("halt_out[%0d]", s), halt_out[s], m_halt[slot]);
        end else begin
          compare_bit($sformatf("halt_out[%0d]", s), halt_out[s], 1'b0);
        end
      end
      if (dispatch_en) begin
        for (int s = 0; s < `NUM_SUPER; s++) begin
          compare_rob_idx($sformatf("rob_idx[%0d]", s), rob_idx[s], m_tail + rob_idx_t'(s));
          compare_phys($sformatf("t_idx[%0d]", s), t_idx[s], lowest_free(s));
        end
      end
      if (inflight.size() >= `NUM_ROB - 1) begin
        full_seen++;
      end
      update_model(exp_retire);
    end
  end

  always @(posedge clock) begin
    cycle_count++;
    if (cycle_count >= timeout_cycles) begin
      $display("Timeout: the run did not end within %0d cycles", timeout_cycles);
      report_failure();
    end
  end

  task automatic drive_inputs(input bit do_dispatch, input bit do_rollback, input bit do_halt,
                              input bit do_complete);
    dispatch_en = 1'b0;
    rollback_en = 1'b0;
    complete_en = '0;
    halt = '0;
    dest_idx[0] = arch_reg_t'(rand_bits(5));
    dest_idx[1] = arch_reg_t'(rand_bits(5));
    // shared destination now and then
    if (rand_bits(3) == 0) begin
      dest_idx[1] = dest_idx[0];
    end
    for (int s = 0; s < `NUM_SUPER; s++) begin
      if (do_complete && inflight.size() > 0 && rand_bits(1)) begin
        complete_en[s] = 1'b1;
        complete_idx[s] = inflight[rand_bits(4) % inflight.size()];
      end
    end
    if (do_rollback && !m_draining && inflight.size() > 0 && rand_bits(4) == 0) begin
      rollback_en = 1'b1;
      rollback_idx = inflight[rand_bits(4) % inflight.size()];
    end else if (do_dispatch && model_ready() && rand_bits(2) != 0) begin
      dispatch_en = 1'b1;
      for (int s = 0; s < `NUM_SUPER; s++) begin
        halt[s] = do_halt && rand_bits(4) == 0;
      end
    end
  endtask

  task automatic run_cycles(input int count, input bit do_dispatch, input bit do_rollback,
                            input bit do_halt, input bit do_complete);
    repeat (count) begin
      drive_inputs(do_dispatch, do_rollback, do_halt, do_complete);
      @(negedge clock);
    end
  endtask

  initial begin
    reset = 1'b1;
    dispatch_en = 1'b0;
    dest_idx = '0;
    halt = '0;
    complete_en = '0;
    complete_idx = '0;
    rollback_en = 1'b0;
    rollback_idx = '0;
    repeat (2) @(posedge clock);
    @(negedge clock);
    reset = 1'b0;
    // fill the ROB before anything completes
    run_cycles(16, 1'b1, 1'b0, 1'b0, 1'b0);
    run_cycles(200, 1'b1, 1'b0, 1'b0, 1'b1);
    run_cycles(150, 1'b1, 1'b1, 1'b0, 1'b1);
    run_cycles(150, 1'b1, 1'b1, 1'b1, 1'b1);
    while (inflight.size() != 0 || m_draining) begin
      run_cycles(1, 1'b0, 1'b0, 1'b0, 1'b1);
    end
    if (UUT.u_checker.violations != 0) begin
      $display("A checker property failed near the end of the run");
      report_failure();
    end else if (rollbacks == 0 || halts_retired == 0 || full_seen == 0) begin
      $display("Stimulus missed a case: rollbacks %0d, halts retired %0d, full cycles %0d",
               rollbacks, halts_retired, full_seen);
      report_failure();
    end else begin
      $display("Everything OK");
      $finish;
    end
  end

endmodule

// ==== verilog/arch_map.sv ====
`timescale 1ns/100ps
`include "core_config.svh"

module arch_map (
  input  logic                                       clock,
  input  logic                                       reset,
  input  logic                  [`NUM_SUPER-1:0]     retire_en,
  input  rename_pkg::arch_reg_t [`NUM_SUPER-1:0]     retire_dest,
  input  rename_pkg::phys_reg_t [`NUM_SUPER-1:0]     retire_t_idx,
  output rename_pkg::phys_reg_t [`NUM_ARCH-1:0]      arch_table
);

  import rename_pkg::*;

  // committed bindings, identity out of reset
  always_ff @(posedge clock) begin
    if (reset) begin
      for (int r = 0; r < `NUM_ARCH; r++) begin
        arch_table[r] <= phys_reg_t'(r);
      end
    end else begin
      // younger retirement last, so it wins
      for (int s = 0; s < `NUM_SUPER; s++) begin
        if (retire_en[s]) begin
          arch_table[retire_dest[s]] <= retire_t_idx[s];
        end
      end
    end
  end

endmodule

// ==== verilog/core_config.svh ====
`ifndef CORE_CONFIG_SVH
`define CORE_CONFIG_SVH

// dispatch and retire width
`define NUM_SUPER 2

// reorder buffer depth
`define NUM_ROB 16

// register file sizes
`define NUM_ARCH 32
`define NUM_PR 64

// name widths
`define ARCH_REG_W $clog2(`NUM_ARCH)
`define PHYS_REG_W $clog2(`NUM_PR)
`define ROB_IDX_W $clog2(`NUM_ROB)

`endif

// ==== verilog/free_list.sv ====
`timescale 1ns/100ps
`include "core_config.svh"

module free_list (
  input  logic                                       clock,
  input  logic                                       reset,
  input  logic                                       alloc_en,
  input  logic                  [`NUM_SUPER-1:0]     release_en,
  input  rename_pkg::phys_reg_t [`NUM_SUPER-1:0]     release_idx,
  input  logic                                       recover,
  input  rename_pkg::phys_reg_t [`NUM_ARCH-1:0]      arch_table,
  output rename_pkg::phys_reg_t [`NUM_SUPER-1:0]     alloc_idx,
  output logic                                       free_ok
);

  import rename_pkg::*;

  logic [`NUM_PR-1:0] free_map;
  logic [`NUM_PR-1:0] free_next;
  logic found_first;
  logic found_second;

  // lowest and second lowest free register
  always_comb begin
    found_first = 1'b0;
    found_second = 1'b0;
    alloc_idx = '0;
    for (int i = 0; i < `NUM_PR; i++) begin
      if (free_map[i]) begin
        if (!found_first) begin
          alloc_idx[0] = phys_reg_t'(i);
          found_first = 1'b1;
        end else if (!found_second) begin
          alloc_idx[1] = phys_reg_t'(i);
          found_second = 1'b1;
        end
      end
    end
  end

  assign free_ok = found_second;

  always_comb begin
    free_next = free_map;
    if (recover) begin
      // everything not held by the committed map is free
      free_next = '1;
      for (int r = 0; r < `NUM_ARCH; r++) begin
        free_next[arch_table[r]] = 1'b0;
      end
    end else begin
      if (alloc_en) begin
        free_next[alloc_idx[0]] = 1'b0;
        free_next[alloc_idx[1]] = 1'b0;
      end
      for (int s = 0; s < `NUM_SUPER; s++) begin
        if (release_en[s]) begin
          free_next[release_idx[s]] = 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      free_map <= {{(`NUM_PR - `NUM_ARCH){1'b1}}, {`NUM_ARCH{1'b0}}};
    end else begin
      free_map <= free_next;
    end
  end

endmodule

// ==== verilog/map_table.sv ====
`timescale 1ns/100ps
`include "core_config.svh"

module map_table (
  input  logic                                       clock,
  input  logic                                       reset,
  input  logic                                       dispatch_en,
  input  rename_pkg::arch_reg_t [`NUM_SUPER-1:0]     dest_idx,
  input  rename_pkg::phys_reg_t [`NUM_SUPER-1:0]     t_idx,
  input  logic                                       recover,
  input  rename_pkg::phys_reg_t [`NUM_ARCH-1:0]      arch_table,
  output rename_pkg::phys_reg_t [`NUM_SUPER-1:0]     told_idx
);

  import rename_pkg::*;

  phys_reg_t [`NUM_ARCH-1:0] spec_map;

  // older slot of the pair may rename the same register
  always_comb begin
    told_idx[0] = spec_map[dest_idx[0]];
    if (dest_idx[1] == dest_idx[0]) begin
      told_idx[1] = t_idx[0];
    end else begin
      told_idx[1] = spec_map[dest_idx[1]];
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int r = 0; r < `NUM_ARCH; r++) begin
        spec_map[r] <= phys_reg_t'(r);
      end
    end else if (recover) begin
      spec_map <= arch_table;
    end else if (dispatch_en) begin
      // slot 1 last so it wins on a shared destination
      for (int s = 0; s < `NUM_SUPER; s++) begin
        spec_map[dest_idx[s]] <= t_idx[s];
      end
    end
  end

endmodule

// ==== verilog/rename_pkg.sv ====
`include "core_config.svh"

package rename_pkg;

  // architectural register name, r0 to r31
  typedef logic [`ARCH_REG_W-1:0] arch_reg_t;

  // physical register name
  typedef logic [`PHYS_REG_W-1:0] phys_reg_t;

endpackage

// ==== verilog/rename_retire.sv ====
`timescale 1ns/100ps
`include "core_config.svh"

module rename_retire (
  input  logic                                       clock,
  input  logic                                       reset,
  input  logic                                       dispatch_en,
  input  rename_pkg::arch_reg_t [`NUM_SUPER-1:0]     dest_idx,
  input  logic                  [`NUM_SUPER-1:0]     halt,
  input  logic                  [`NUM_SUPER-1:0]     complete_en,
  input  rob_pkg::rob_idx_t     [`NUM_SUPER-1:0]     complete_idx,
  input  logic                                       rollback_en,
  input  rob_pkg::rob_idx_t                          rollback_idx,
  output logic                                       dispatch_ready,
  output rob_pkg::rob_idx_t     [`NUM_SUPER-1:0]     rob_idx,
  output rename_pkg::phys_reg_t [`NUM_SUPER-1:0]     t_idx,
  output logic                  [`NUM_SUPER-1:0]     retire_en,
  output rename_pkg::arch_reg_t [`NUM_SUPER-1:0]     retire_dest,
  output rename_pkg::phys_reg_t [`NUM_SUPER-1:0]     retire_t_idx,
  output rename_pkg::phys_reg_t [`NUM_SUPER-1:0]     retire_told_idx,
  output logic                  [`NUM_SUPER-1:0]     halt_out
);

  import rename_pkg::*;

  phys_reg_t [`NUM_SUPER-1:0] told_idx;
  phys_reg_t [`NUM_ARCH-1:0] arch_table;
  logic rob_ready;
  logic free_ok;
  logic recover;

  // needs two ROB slots and two free registers
  assign dispatch_ready = rob_ready & free_ok;

  rob u_rob (
    .clock           (clock),
    .reset           (reset),
    .dispatch_en     (dispatch_en),
    .dest_idx        (dest_idx),
    .halt            (halt),
    .t_idx           (t_idx),
    .told_idx        (told_idx),
    .complete_en     (complete_en),
    .complete_idx    (complete_idx),
    .rollback_en     (rollback_en),
    .rollback_idx    (rollback_idx),
    .rob_ready       (rob_ready),
    .rob_idx         (rob_idx),
    .retire_en       (retire_en),
    .retire_dest     (retire_dest),
    .retire_t_idx    (retire_t_idx),
    .retire_told_idx (retire_told_idx),
    .halt_out        (halt_out),
    .recover         (recover)
  );

  free_list u_free_list (
    .clock       (clock),
    .reset       (reset),
    .alloc_en    (dispatch_en),
    .release_en  (retire_en),
    .release_idx (retire_told_idx),
    .recover     (recover),
    .arch_table  (arch_table),
    .alloc_idx   (t_idx),
    .free_ok     (free_ok)
  );

  map_table u_map_table (
    .clock       (clock),
    .reset       (reset),
    .dispatch_en (dispatch_en),
    .dest_idx    (dest_idx),
    .t_idx       (t_idx),
    .recover     (recover),
    .arch_table  (arch_table),
    .told_idx    (told_idx)
  );

  arch_map u_arch_map (
    .clock        (clock),
    .reset        (reset),
    .retire_en    (retire_en),
    .retire_dest  (retire_dest),
    .retire_t_idx (retire_t_idx),
    .arch_table   (arch_table)
  );

endmodule

// ==== verilog/rob.sv ====
`timescale 1ns/100ps
`include "core_config.svh"

module rob (
  input  logic                                       clock,
  input  logic                                       reset,
  input  logic                                       dispatch_en,
  input  rename_pkg::arch_reg_t [`NUM_SUPER-1:0]     dest_idx,
  input  logic                  [`NUM_SUPER-1:0]     halt,
  input  rename_pkg::phys_reg_t [`NUM_SUPER-1:0]     t_idx,
  input  rename_pkg::phys_reg_t [`NUM_SUPER-1:0]     told_idx,
  input  logic                  [`NUM_SUPER-1:0]     complete_en,
  input  rob_pkg::rob_idx_t     [`NUM_SUPER-1:0]     complete_idx,
  input  logic                                       rollback_en,
  input  rob_pkg::rob_idx_t                          rollback_idx,
  output logic                                       rob_ready,
  output rob_pkg::rob_idx_t     [`NUM_SUPER-1:0]     rob_idx,
  output logic                  [`NUM_SUPER-1:0]     retire_en,
  output rename_pkg::arch_reg_t [`NUM_SUPER-1:0]     retire_dest,
  output rename_pkg::phys_reg_t [`NUM_SUPER-1:0]     retire_t_idx,
  output rename_pkg::phys_reg_t [`NUM_SUPER-1:0]     retire_told_idx,
  output logic                  [`NUM_SUPER-1:0]     halt_out,
  output logic                                       recover
);

  import rename_pkg::*;
  import rob_pkg::*;

  // entry payload
  arch_reg_t entry_dest [`NUM_ROB];
  phys_reg_t entry_t [`NUM_ROB];
  phys_reg_t entry_told [`NUM_ROB];

  logic [`NUM_ROB-1:0] valid, valid_next;
  logic [`NUM_ROB-1:0] complete, complete_next;
  logic [`NUM_ROB-1:0] halt_bits, halt_next;
  logic [`NUM_ROB-1:0] flush_mask;

  rob_idx_t head, head_next;
  rob_idx_t tail, tail_next;
  rob_idx_t [`NUM_SUPER-1:0] head_slot;
  rob_idx_t retire_cnt;
  rob_idx_t branch_age;
  rob_state_t state, state_next;

  logic mispredict;
  logic rob_empty;
  logic halt_held;
  logic tail_free;

  assign rob_empty = ~|valid;
  assign halt_held = |(valid & halt_bits);
  assign mispredict = rollback_en && valid[rollback_idx];
  assign recover = (state == rob_draining) && rob_empty;

  always_comb begin
    retire_cnt = '0;
    tail_free = 1'b1;
    for (int s = 0; s < `NUM_SUPER; s++) begin
      rob_idx[s] = tail + rob_idx_t'(s);
      head_slot[s] = head + rob_idx_t'(s);
      tail_free = tail_free & ~valid[rob_idx[s]];
      // in order, each slot needs the older one to go too
      retire_en[s] = valid[head_slot[s]] & complete[head_slot[s]] & ~rollback_en;
      if (s > 0) begin
        retire_en[s] = retire_en[s] & retire_en[s-1];
      end
      retire_dest[s] = entry_dest[head_slot[s]];
      retire_t_idx[s] = entry_t[head_slot[s]];
      retire_told_idx[s] = entry_told[head_slot[s]];
      halt_out[s] = retire_en[s] & halt_bits[head_slot[s]];
      retire_cnt = retire_cnt + rob_idx_t'(retire_en[s]);
    end
  end

  assign rob_ready = (state == rob_normal) && !rollback_en && tail_free && !halt_held;

  // age relative to head handles the wrap
  assign branch_age = rollback_idx - head;

  always_comb begin
    flush_mask = '0;
    for (int i = 0; i < `NUM_ROB; i++) begin
      if (rob_idx_t'(rob_idx_t'(i) - head) > branch_age) begin
        flush_mask[i] = 1'b1;
      end
    end
  end

  always_comb begin
    valid_next = valid;
    complete_next = complete;
    halt_next = halt_bits;
    for (int s = 0; s < `NUM_SUPER; s++) begin
      if (complete_en[s] && valid[complete_idx[s]]) begin
        complete_next[complete_idx[s]] = 1'b1;
      end
      if (retire_en[s]) begin
        valid_next[head_slot[s]] = 1'b0;
      end
      if (dispatch_en) begin
        valid_next[rob_idx[s]] = 1'b1;
        complete_next[rob_idx[s]] = 1'b0;
        halt_next[rob_idx[s]] = halt[s];
      end
    end
    if (mispredict) begin
      valid_next = valid_next & ~flush_mask;
    end
  end

  assign head_next = head + retire_cnt;
  assign tail_next = mispredict  ? rollback_idx + rob_idx_t'(1) :
                     dispatch_en ? tail + rob_idx_t'(`NUM_SUPER) :
                                   tail;

  // another rollback while draining just flushes further
  always_comb begin
    state_next = state;
    case (state)
      rob_normal: begin
        if (mispredict) begin
          state_next = rob_draining;
        end
      end
      rob_draining: begin
        if (rob_empty) begin
          state_next = rob_normal;
        end
      end
      default: state_next = rob_normal;
    endcase
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      head <= '0;
      tail <= '0;
      state <= rob_normal;
      valid <= '0;
      complete <= '0;
      halt_bits <= '0;
    end else begin
      head <= head_next;
      tail <= tail_next;
      state <= state_next;
      valid <= valid_next;
      complete <= complete_next;
      halt_bits <= halt_next;
    end
  end

  always_ff @(posedge clock) begin
    if (dispatch_en) begin
      for (int s = 0; s < `NUM_SUPER; s++) begin
        entry_dest[rob_idx[s]] <= dest_idx[s];
        entry_t[rob_idx[s]] <= t_idx[s];
        entry_told[rob_idx[s]] <= told_idx[s];
      end
    end
  end

endmodule

// ==== verilog/rob_pkg.sv ====
`include "core_config.svh"

package rob_pkg;

  // slot in the reorder buffer
  typedef logic [`ROB_IDX_W-1:0] rob_idx_t;

  // draining lasts from a rollback until the buffer is empty
  typedef enum logic {
    rob_normal,
    rob_draining
  } rob_state_t;

endpackage
